/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tbArmController
FILELIST  = project.f
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* armController.sv */
`timescale 1ns/1ps
`default_nettype none

module armController
  import armIsaPkg::*;
  import ctrlPkg::*;
#(
  parameter flagsT ResetFlags = '0
) (
  input  logic       clk,
  input  logic       rstN,
  input  instrWordT  instrD,
  input  flagsT      aluFlagsE,
  input  logic [1:0] addrLowE,
  input  logic       stall,
  input  logic       flushD,
  input  logic       flushE,
  output decodeCtrlT decodeCtrlD,
  output execCtrlT   execCtrlE,
  output memCtrlT    memCtrlM,
  output wbCtrlT     wbCtrlW,
  output flagsT      flags,
  output logic       pcWrPending
);

  pipeCtrlT pipeD;
  memCtrlT  memCtrlE;
  wbCtrlT   wbCtrlE;
  logic     setFlagsE;
  flagsT    flagsNextE;
  flagsT    fwdFlags;
  logic     pcSrcE;
  logic     pcSrcM;

  // ==============================
  // Stage blocks
  // ==============================
  instrDecoder instrDecoder_i (
    .instr      (instrD),
    .decodeCtrl (decodeCtrlD),
    .pipe       (pipeD)
  );

  execStage execStage_i (
    .clk       (clk),
    .rstN      (rstN),
    .stall     (stall),
    .flushD    (flushD),
    .flushE    (flushE),
    .pipeD     (pipeD),
    .aluFlags  (aluFlagsE),
    .fwdFlags  (fwdFlags),
    .addrLow   (addrLowE),
    .execCtrl  (execCtrlE),
    .memCtrl   (memCtrlE),
    .wbCtrl    (wbCtrlE),
    .setFlags  (setFlagsE),
    .flagsNext (flagsNextE),
    .pcSrcE    (pcSrcE)
  );

  memWbStage #(
    .ResetFlags (ResetFlags)
  ) memWbStage_i (
    .clk        (clk),
    .rstN       (rstN),
    .stall      (stall),
    .memCtrlE   (memCtrlE),
    .wbCtrlE    (wbCtrlE),
    .setFlagsE  (setFlagsE),
    .flagsNextE (flagsNextE),
    .memCtrl    (memCtrlM),
    .wbCtrl     (wbCtrlW),
    .pcSrcM     (pcSrcM),
    .fwdFlags   (fwdFlags),
    .flags      (flags)
  );

  // PC write in flight in D, E or M
  assign pcWrPending = pipeD.pcSrc || pcSrcE || pcSrcM;

endmodule

`default_nettype wire

/* armController_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module armController_checker
  import ctrlPkg::*;
(
  input logic     clk,
  input logic     rstN,
  input logic     stall,
  input execCtrlT execCtrlE,
  input memCtrlT  memCtrlM,
  input wbCtrlT   wbCtrlW,
  input flagsT    flags,
  input logic     pcWrPending
);

  // Sticky per-property failure bits, read by the testbench
  logic resetErr   = 1'b0;
  logic maskErr    = 1'b0;
  logic pcStoreErr = 1'b0;
  logic holdErr    = 1'b0;
  logic anyFail;

  assign anyFail = resetErr || maskErr || pcStoreErr || holdErr;

  // ==============================
  // Properties
  // ==============================
  idleAfterReset: assert property (@(posedge clk)
    $rose(rstN) |-> !(memCtrlM.memWrite || wbCtrlW.regWrite || wbCtrlW.pcSrc ||
                      execCtrlE.branchTaken || pcWrPending))
    else begin
      resetErr = 1'b1;
      $error("Strobe high in the first cycle after reset");
    end

  // Store is a full word or a single lane
  storeLanes: assert property (@(posedge clk) disable iff (!rstN)
    memCtrlM.memWrite |-> (memCtrlM.byteMask == 4'b1111) || $onehot(memCtrlM.byteMask))
    else begin
      maskErr = 1'b1;
      $error("Store byte mask is neither a word nor one lane");
    end

  // Same instruction moves M to W on the next unstalled edge
  storeNotPc: assert property (@(posedge clk) disable iff (!rstN)
    memCtrlM.memWrite && !stall |=> !wbCtrlW.pcSrc)
    else begin
      pcStoreErr = 1'b1;
      $error("Store in M followed by a PC write in W");
    end

  holdOnStall: assert property (@(posedge clk) disable iff (!rstN)
    stall |=> $stable(memCtrlM) && $stable(wbCtrlW) && $stable(flags) &&
              $stable(execCtrlE))
    else begin
      holdErr = 1'b1;
      $error("Outputs changed across a stall");
    end

endmodule

bind armController armController_checker checker_i (
  .clk         (clk),
  .rstN        (rstN),
  .stall       (stall),
  .execCtrlE   (execCtrlE),
  .memCtrlM    (memCtrlM),
  .wbCtrlW     (wbCtrlW),
  .flags       (flags),
  .pcWrPending (pcWrPending)
);

`default_nettype wire

/* armIsaPkg.sv */
`default_nettype none

package armIsaPkg;

  // ==============================
  // Condition field
  // ==============================
  typedef enum logic [3:0] {
    CondEq, CondNe, CondCs, CondCc,   // Zero and carry tests
    CondMi, CondPl, CondVs, CondVc,   // Sign and overflow tests
    CondHi, CondLs, CondGe, CondLt,   // Unsigned and signed compares
    CondGt, CondLe, CondAl, CondNv    // NV never executes here
  } condT;

  // Data-processing opcode, bits 24:21
  typedef enum logic [3:0] {
    OpAnd, OpEor, OpSub, OpRsb,
    OpAdd, OpAdc, OpSbc, OpRsc,
    OpTst, OpTeq, OpCmp, OpCmn,       // Flag-only group
    OpOrr, OpMov, OpBic, OpMvn
  } aluOpT;

  // Class bits 27:26
  typedef enum logic [1:0] {
    ClassDp     = 2'b00,              // Data processing and misc
    ClassMem    = 2'b01,              // Single load/store
    ClassBranch = 2'b10,              // B, also LDM/STM space
    ClassOther  = 2'b11               // Coprocessor and SWI
  } instrClassT;

  // ==============================
  // Instruction word views
  // ==============================
  typedef struct packed {
    condT        cond;
    instrClassT  cls;
    logic        immBit;              // Operand2 is rotated immediate
    aluOpT       opcode;
    logic        sBit;                // Update flags
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] operand2;
  } dpFieldsT;

  typedef struct packed {
    condT        cond;
    instrClassT  cls;
    logic        regOffset;           // Offset is a shifted register
    logic        p;                   // Pre-index
    logic        u;                   // Add offset when set
    logic        b;                   // Byte access
    logic        w;                   // Base write-back
    logic        l;                   // Load when set
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset;
  } memFieldsT;

  typedef union packed {
    dpFieldsT    dp;
    memFieldsT   mem;
    logic [31:0] raw;
  } instrWordT;

  localparam logic [3:0] PcReg = 4'd15;  // R15

endpackage

`default_nettype wire

/* condCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module condCheck
  import armIsaPkg::*;
  import ctrlPkg::*;
(
  input  condT       cond,
  input  flagsT      flagsIn,     // Forwarded NZCV
  input  flagsT      aluFlags,
  input  logic [1:0] flagWrite,   // [1] NZ, [0] CV
  output logic       condEx,
  output flagsT      flagsNext
);

  logic signedGe;

  assign signedGe = (flagsIn.n == flagsIn.v);

  // ==============================
  // Condition evaluation
  // ==============================
  always_comb begin
    unique case (cond)
      CondEq:  condEx = flagsIn.z;
      CondNe:  condEx = !flagsIn.z;
      CondCs:  condEx = flagsIn.c;
      CondCc:  condEx = !flagsIn.c;
      CondMi:  condEx = flagsIn.n;
      CondPl:  condEx = !flagsIn.n;
      CondVs:  condEx = flagsIn.v;
      CondVc:  condEx = !flagsIn.v;
      CondHi:  condEx = flagsIn.c && !flagsIn.z;          // Unsigned higher
      CondLs:  condEx = !flagsIn.c || flagsIn.z;
      CondGe:  condEx = signedGe;
      CondLt:  condEx = !signedGe;
      CondGt:  condEx = !flagsIn.z && signedGe;
      CondLe:  condEx = flagsIn.z || !signedGe;
      CondAl:  condEx = 1'b1;
      default: condEx = 1'b0;                             // NV
    endcase
  end

  // Merge new flags by group
  always_comb begin
    flagsNext = flagsIn;
    if (flagWrite[1]) begin
      flagsNext.n = aluFlags.n;
      flagsNext.z = aluFlags.z;
    end
    if (flagWrite[0]) begin
      flagsNext.c = aluFlags.c;
      flagsNext.v = aluFlags.v;
    end
  end

endmodule

`default_nettype wire

/* controller_input.txt */
// instrD aluFlagsE addrLowE stall flushD flushE expWbW expMemM expFlags name
// aluFlagsE and addrLowE serve the instruction of the previous line, now in E
EF000000 0 0 0 0 0 0 00 0 reset_idle
E0921003 0 0 0 0 0 0 00 0 adds_issue
E0121003 3 0 0 0 0 0 00 0 ands_issue
E1520003 C 0 0 0 0 0 00 0 cmp_issue
03A04001 6 0 0 0 0 4 00 0 adds_wb
13A04001 0 0 0 0 0 4 00 3 adds_flags
A3A04001 0 0 0 0 0 0 00 F ands_nz_only
B3A04001 0 0 0 0 0 4 00 6 moveq_taken
E3A04001 0 0 0 0 0 0 00 6 movne_skip
E3120001 0 0 0 0 0 4 00 6 movge_taken
E5865004 B 0 0 0 0 0 00 6 movlt_skip
E5C65002 0 0 0 0 0 4 00 6 moval_wb
E5967000 0 2 0 0 0 0 2F 6 str_word
EA000004 0 0 0 0 0 0 24 A strb_lane2
0A000004 0 0 0 0 0 0 1F A ldr_mem
EF000000 0 0 0 0 0 6 00 A ldr_wb
EF000000 0 0 0 0 0 1 00 A b_taken
E5967000 0 0 0 0 0 0 00 A beq_skip
EF000000 0 0 0 0 0 0 00 A stall_pre
EF000000 0 0 1 0 0 0 1F A stall_hold
EF000000 0 0 0 0 0 0 1F A stall_held
E0921003 0 0 0 0 1 6 00 A ldr_wb_late
EF000000 0 0 0 0 0 0 00 A flush_e
EF000000 0 0 0 0 0 0 00 A flush_m
EF000000 0 0 0 0 0 0 00 A flush_w
EF000000 0 0 0 0 0 0 00 A flush_flags

/* ctrlPkg.sv */
`default_nettype none

package ctrlPkg;

  import armIsaPkg::*;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ==============================
  // Per-stage control bundles
  // ==============================
  typedef struct packed {
    logic [1:0] regSrc;               // Register file read selects
    logic [1:0] immSrc;               // Immediate extension format
  } decodeCtrlT;

  typedef struct packed {
    logic  aluSrc;                    // 1 selects the immediate
    aluOpT aluControl;
    logic  branchTaken;
    logic  memToReg;
  } execCtrlT;

  typedef struct packed {
    logic       memWrite;
    logic       memToReg;
    logic [3:0] byteMask;             // Store lane enables
  } memCtrlT;

  typedef struct packed {
    logic regWrite;
    logic memToReg;                   // Result from data memory
    logic pcSrc;                      // Result goes to PC
  } wbCtrlT;

  // Decode to Execute bundle, ungated by condition
  typedef struct packed {
    condT       cond;
    logic [1:0] flagWrite;            // [1] NZ, [0] CV
    logic       branch;
    logic       memWrite;
    logic       regWrite;
    logic       memToReg;
    logic       pcSrc;
    logic       noWrite;              // Compare/test, kills regWrite
    logic       isByte;
    logic       aluSrc;
    aluOpT      aluControl;
    instrClassT opClass;
  } pipeCtrlT;

endpackage

`default_nettype wire

/* execStage.sv */
`timescale 1ns/1ps
`default_nettype none

module execStage
  import armIsaPkg::*;
  import ctrlPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       stall,
  input  logic       flushD,
  input  logic       flushE,
  input  pipeCtrlT   pipeD,
  input  flagsT      aluFlags,
  input  flagsT      fwdFlags,     // Flags as seen by this instruction
  input  logic [1:0] addrLow,
  output execCtrlT   execCtrl,
  output memCtrlT    memCtrl,
  output wbCtrlT     wbCtrl,
  output logic       setFlags,
  output flagsT      flagsNext,
  output logic       pcSrcE
);

  logic       validD;             // Low while D holds a flushed slot
  pipeCtrlT   pipeE;
  logic       condEx;
  logic [3:0] byteMask;

  // ==============================
  // D valid and E register
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)        validD <= 1'b0;
    else if (flushD)  validD <= 1'b0;                     // Flush beats stall
    else if (!stall)  validD <= 1'b1;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)        pipeE <= '0;
    else if (flushE)  pipeE <= '0;
    else if (!stall)  pipeE <= validD ? pipeD : '0;       // Dead slot enters as a bubble
  end

  condCheck condCheck_i (
    .cond      (pipeE.cond),
    .flagsIn   (fwdFlags),
    .aluFlags  (aluFlags),
    .flagWrite (pipeE.flagWrite),
    .condEx    (condEx),
    .flagsNext (flagsNext)
  );

  // Store lanes, zero outside memory ops
  always_comb begin
    if (pipeE.opClass != ClassMem) byteMask = 4'b0000;
    else if (pipeE.isByte)         byteMask = 4'b0001 << addrLow;
    else                           byteMask = 4'b1111;
  end

  // ==============================
  // Condition gating
  // ==============================
  assign execCtrl.aluSrc      = pipeE.aluSrc;
  assign execCtrl.aluControl  = pipeE.aluControl;
  assign execCtrl.branchTaken = pipeE.branch && condEx;
  assign execCtrl.memToReg    = pipeE.memToReg;

  assign memCtrl.memWrite = pipeE.memWrite && condEx;
  assign memCtrl.memToReg = pipeE.memToReg;
  assign memCtrl.byteMask = byteMask;

  assign wbCtrl.regWrite = pipeE.regWrite && !pipeE.noWrite && condEx;
  assign wbCtrl.memToReg = pipeE.memToReg;
  assign wbCtrl.pcSrc    = pipeE.pcSrc && condEx;

  assign setFlags = (pipeE.flagWrite != 2'b00) && condEx;
  assign pcSrcE   = wbCtrl.pcSrc;

endmodule

`default_nettype wire

/* instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
  import armIsaPkg::*;
  import ctrlPkg::*;
(
  input  instrWordT  instr,
  output decodeCtrlT decodeCtrl,
  output pipeCtrlT   pipe
);

  logic isDp;
  logic isMem;
  logic isBranch;
  logic isCompare;
  logic isLogic;

  // ==============================
  // Classification
  // ==============================
  assign isCompare = instr.dp.opcode inside {OpTst, OpTeq, OpCmp, OpCmn};
  assign isLogic   = instr.dp.opcode inside {OpAnd, OpEor, OpTst, OpTeq,
                                             OpOrr, OpMov, OpBic, OpMvn};

  // Bit 4 set with a register operand is mul, halfword or reg-shift space
  assign isDp = (instr.dp.cls == ClassDp) &&
                (instr.dp.immBit || !instr.dp.operand2[4]) &&
                !(isCompare && !instr.dp.sBit);           // MSR/MRS space

  // Register offset with bit 4 set is undefined
  assign isMem = (instr.mem.cls == ClassMem) &&
                 !(instr.mem.regOffset && instr.mem.offset[4]);

  assign isBranch = (instr.dp.cls == ClassBranch) && instr.dp.immBit;  // Bit 25 clear is LDM/STM

  // ==============================
  // Control generation
  // ==============================
  always_comb begin
    decodeCtrl      = '0;
    pipe            = '0;                                 // Anything unknown is a no-op
    pipe.cond       = instr.dp.cond;
    pipe.aluControl = OpAdd;
    pipe.opClass    = ClassOther;

    if (isDp) begin
      pipe.opClass    = ClassDp;
      pipe.aluSrc     = instr.dp.immBit;
      pipe.aluControl = instr.dp.opcode;
      pipe.regWrite   = 1'b1;
      pipe.noWrite    = isCompare;                        // TST, TEQ, CMP, CMN
      if (instr.dp.sBit) begin
        pipe.flagWrite = {1'b1, !isLogic};                // Logical ops keep C and V
      end
    end else if (isMem) begin
      decodeCtrl.regSrc = instr.mem.l ? 2'b00 : 2'b10;   // Store reads Rd as data
      decodeCtrl.immSrc = 2'b01;                          // 12-bit offset
      pipe.opClass      = ClassMem;
      pipe.aluSrc       = !instr.mem.regOffset;
      pipe.aluControl   = instr.mem.u ? OpAdd : OpSub;    // Up/down offset
      pipe.isByte       = instr.mem.b;
      pipe.memWrite     = !instr.mem.l;
      pipe.regWrite     = instr.mem.l;
      pipe.memToReg     = instr.mem.l;
    end else if (isBranch) begin
      decodeCtrl.regSrc = 2'b01;                          // Base is PC
      decodeCtrl.immSrc = 2'b10;                          // 24-bit word offset
      pipe.opClass      = ClassBranch;
      pipe.aluSrc       = 1'b1;
      pipe.branch       = 1'b1;                           // Link bit is not decoded
    end

    // Any write to R15 or a branch redirects fetch
    pipe.pcSrc = (pipe.regWrite && !pipe.noWrite && instr.dp.rd == PcReg) ||
                 pipe.branch;
  end

endmodule

`default_nettype wire

/* memWbStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memWbStage
  import ctrlPkg::*;
#(
  parameter flagsT ResetFlags = '0
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    stall,
  input  memCtrlT memCtrlE,
  input  wbCtrlT  wbCtrlE,
  input  logic    setFlagsE,
  input  flagsT   flagsNextE,
  output memCtrlT memCtrl,       // M stage
  output wbCtrlT  wbCtrl,        // W stage
  output logic    pcSrcM,
  output flagsT   fwdFlags,
  output flagsT   flags          // Architectural NZCV
);

  wbCtrlT wbCtrlM;
  logic   setFlagsM;
  logic   setFlagsW;
  flagsT  flagsM;
  flagsT  flagsW;

  // ==============================
  // M and W control registers
  // ==============================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memCtrl   <= '0;
      wbCtrlM   <= '0;
      setFlagsM <= 1'b0;
      wbCtrl    <= '0;
      setFlagsW <= 1'b0;
    end else if (!stall) begin
      memCtrl   <= memCtrlE;
      wbCtrlM   <= wbCtrlE;
      setFlagsM <= setFlagsE;
      wbCtrl    <= wbCtrlM;
      setFlagsW <= setFlagsM;
    end
  end

  // Pending flags, only read when the matching set bit is high
  always_ff @(posedge clk) begin
    if (!stall) begin
      flagsM <= flagsNextE;
      flagsW <= flagsM;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)                    flags <= ResetFlags;
    else if (setFlagsW && !stall) flags <= flagsW;
  end

  // Youngest pending update wins
  assign fwdFlags = setFlagsM ? flagsM :
                    setFlagsW ? flagsW : flags;

  assign pcSrcM = wbCtrlM.pcSrc;

endmodule

`default_nettype wire

/* project.f */
armIsaPkg.sv
ctrlPkg.sv
condCheck.sv
instrDecoder.sv
execStage.sv
memWbStage.sv
armController.sv
armController_checker.sv
tbArmController.sv

/* tbArmController.sv */
`timescale 1ns/1ps
`default_nettype none

module tbArmController
  import armIsaPkg::*;
  import ctrlPkg::*;
();

  localparam int    HalfPeriod  = 2;       // 4 ns clock
  localparam int    ResetCycles = 4;
  localparam int    SlackCycles = 20;
  localparam int    SampleDelay = 1;       // After falling edge, before rising edge
  localparam flagsT ResetFlags  = '0;
  localparam string InputFile   = "controller_input.txt";

  // One stimulus line with its expected results
  typedef struct packed {
    instrWordT       instr;
    flagsT           aluFlags;
    logic [1:0]      addrLow;
    logic            stall;
    logic            flushD;
    logic            flushE;
    wbCtrlT          expWb;
    memCtrlT         expMem;
    flagsT           expFlags;
    logic [8*16-1:0] name;
  } vectorT;

  vectorT vectors[$];

  logic       clk = 1'b0;
  logic       rstN;
  instrWordT  instrD;
  flagsT      aluFlagsE;
  logic [1:0] addrLowE;
  logic       stall;
  logic       flushD;
  logic       flushE;
  decodeCtrlT decodeCtrlD;
  execCtrlT   execCtrlE;
  memCtrlT    memCtrlM;
  wbCtrlT     wbCtrlW;
  flagsT      flags;
  logic       pcWrPending;
  logic       expPending;         // PC write in D, E or M
  logic       expTaken;           // Branch in E passes its condition
  int         cycleCount = 0;
  int         cycleLimit = 0;     // Set once the vectors are loaded

  armController #(
    .ResetFlags (ResetFlags)
  ) dut_i (
    .clk         (clk),
    .rstN        (rstN),
    .instrD      (instrD),
    .aluFlagsE   (aluFlagsE),
    .addrLowE    (addrLowE),
    .stall       (stall),
    .flushD      (flushD),
    .flushE      (flushE),
    .decodeCtrlD (decodeCtrlD),
    .execCtrlE   (execCtrlE),
    .memCtrlM    (memCtrlM),
    .wbCtrlW     (wbCtrlW),
    .flags       (flags),
    .pcWrPending (pcWrPending)
  );

  always #HalfPeriod clk = ~clk;

  // ==============================
  // Helpers
  // ==============================
  task automatic abortRun();
    $display("Simulation failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic checkWb(input logic [8*16-1:0] name, input wbCtrlT expected,
                         input wbCtrlT actual);
    if (actual !== expected) begin
      $display("Error: %0s wbCtrlW expected %b actual %b", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkMem(input logic [8*16-1:0] name, input memCtrlT expected,
                          input memCtrlT actual);
    if (actual !== expected) begin
      $display("Error: %0s memCtrlM expected %b actual %b", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkFlags(input logic [8*16-1:0] name, input flagsT expected,
                            input flagsT actual);
    if (actual !== expected) begin
      $display("Error: %0s flags expected %b actual %b", name, expected, actual);
      abortRun();
    end
  endtask

  // Single-bit strobes and levels
  task automatic checkBit(input logic [8*16-1:0] name, input string what,
                          input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error: %0s %0s expected %b actual %b", name, what, expected, actual);
      abortRun();
    end
  endtask

  // B encoding, bits 27:25 = 101
  function automatic logic isBranchWord(input instrWordT w);
    return w.raw[27:25] == 3'b101;
  endfunction

  // Expected W pcSrc of a later line, zero past the end
  function automatic logic wbPcSrcAt(input int idx);
    if (idx < vectors.size()) return vectors[idx].expWb.pcSrc;
    return 1'b0;
  endfunction

  // Comment lines fail the first hex field and are skipped
  task automatic readVectors();
    int              fd;
    int              count;
    logic [8*96-1:0] lineBuf;
    logic [31:0]     instrHex;
    logic [3:0]      aluHex;
    logic [1:0]      addrHex;
    logic            stallHex;
    logic            flushDHex;
    logic            flushEHex;
    logic [2:0]      wbHex;
    logic [5:0]      memHex;
    logic [3:0]      flagsHex;
    logic [8*16-1:0] nameBuf;
    vectorT          v;
    fd = $fopen(InputFile, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %0s", InputFile);
      abortRun();
    end
    while (!$feof(fd)) begin
      lineBuf = '0;
      count   = $fgets(lineBuf, fd);
      if (count > 0) begin
        count = $sscanf(lineBuf, "%h %h %h %h %h %h %h %h %h %s", instrHex, aluHex,
                        addrHex, stallHex, flushDHex, flushEHex, wbHex, memHex,
                        flagsHex, nameBuf);
        if (count == 10) begin
          v.instr    = instrHex;
          v.aluFlags = aluHex;
          v.addrLow  = addrHex;
          v.stall    = stallHex;
          v.flushD   = flushDHex;
          v.flushE   = flushEHex;
          v.expWb    = wbHex;
          v.expMem   = memHex;
          v.expFlags = flagsHex;
          v.name     = nameBuf;
          vectors.push_back(v);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic applyVector(input vectorT v);
    instrD    = v.instr;
    aluFlagsE = v.aluFlags;     // Belongs to the instruction now in E
    addrLowE  = v.addrLow;
    stall     = v.stall;
    flushD    = v.flushD;
    flushE    = v.flushE;
  endtask

  // ==============================
  // Timeout
  // ==============================
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, the stimulus loop did not finish", cycleLimit);
      abortRun();
    end
  end

  // ==============================
  // Stimulus and checks
  // ==============================
  initial begin
    rstN       = 1'b0;
    instrD.raw = 32'hEF00_0000;   // SWI space, decodes to nothing
    aluFlagsE  = '0;
    addrLowE   = '0;
    stall      = 1'b0;
    flushD     = 1'b0;
    flushE     = 1'b0;
    readVectors();
    if (vectors.size() == 0) begin
      $display("No stimulus lines found in %0s", InputFile);
      abortRun();
    end
    cycleLimit = ResetCycles + vectors.size() + SlackCycles;

    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    foreach (vectors[i]) begin
      applyVector(vectors[i]);
      // E is two edges before W, M one edge
      expPending = isBranchWord(vectors[i].instr) || wbPcSrcAt(i + 1) ||
                   wbPcSrcAt(i + 2);
      expTaken   = (i > 0) && isBranchWord(vectors[i - 1].instr) && wbPcSrcAt(i + 2);
      #SampleDelay;                 // Registered outputs settled
      checkMem(vectors[i].name, vectors[i].expMem, memCtrlM);
      checkWb(vectors[i].name, vectors[i].expWb, wbCtrlW);
      checkFlags(vectors[i].name, vectors[i].expFlags, flags);
      checkBit(vectors[i].name, "pcWrPending", expPending, pcWrPending);
      checkBit(vectors[i].name, "branchTaken", expTaken, execCtrlE.branchTaken);
      @(negedge clk);
    end

    if (dut_i.checker_i.anyFail) begin
      $display("A bound assertion on the controller failed during the run");
      abortRun();
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire
